// File: design/kernel_cfg_pkg.sv
/* Kernel compute unit configuration */
`default_nettype none

package kernel_cfg_pkg;

  // ------------------------------
  // Bus widths
  // ------------------------------
  localparam int ADDR_W  = 32;
  localparam int DATA_W  = 32;
  localparam int COUNT_W = 16;

  // Requestors sharing the memory port
  localparam int NUM_REQUESTORS = 2;
  localparam int REQ_ID_SETUP   = 0;
  localparam int REQ_ID_BUNDLE  = 1;

  // Quiet cycles on the port before done
  localparam int DONE_HOLD = 8;

  // Word offsets inside the config block
  localparam int CFG_DATA_BASE_OFS = 0;
  localparam int CFG_COUNT_OFS     = 1;

endpackage : kernel_cfg_pkg

`default_nettype wire

// File: design/kernel_types_pkg.sv
/* Kernel compute unit types */
`default_nettype none

package kernel_types_pkg;
  import kernel_cfg_pkg::*;

  // Word address on the memory port
  typedef logic [ADDR_W-1:0] addr_t;

  // Data word, also the running sum
  typedef logic [DATA_W-1:0] word_t;

  // Vertex count, low bits of the count word
  typedef logic [COUNT_W-1:0] count_t;

  // Requestor index on the arbiter
  typedef logic [$clog2(NUM_REQUESTORS)-1:0] req_id_t;

  // Done-hold counter, must reach DONE_HOLD
  typedef logic [$clog2(DONE_HOLD+1)-1:0] hold_cnt_t;

  // Top-level sequencing states
  typedef enum logic [2:0] {
    IDLE,
    SETUP,
    BUNDLES,
    DRAIN,
    DONE
  } kernel_state_t;

endpackage : kernel_types_pkg

`default_nettype wire

// File: design/mem_req_if.sv
/* Four-phase memory request link */
`default_nettype none

interface mem_req_if
  import kernel_types_pkg::*;
();

  // Requestor side of the handshake
  logic  req;
  addr_t addr;

  // Arbiter side of the handshake
  logic  ack;
  word_t rdata;

  // Requestor raises req with addr stable, drops it after ack
  modport requestor (
    output req,
    output addr,
    input  ack,
    input  rdata
  );

  // Arbiter answers with ack and rdata, drops ack after req falls
  modport arbiter (
    input  req,
    input  addr,
    output ack,
    output rdata
  );

endinterface : mem_req_if

`default_nettype wire

// File: design/kernel_control.sv
/* Kernel sequencing control */
`default_nettype none

module kernel_control
  import kernel_cfg_pkg::*;
  import kernel_types_pkg::*;
(
  input  logic  ap_clk,
  input  logic  areset_control,
  input  logic  desc_valid,
  input  addr_t desc_base,
  output logic  setup_start,
  input  logic  setup_done,
  output logic  setup_flush,
  output logic  bundle_start,
  input  logic  bundle_done,
  input  logic  port_busy,
  output logic  rst_q,
  output addr_t base_q,
  output logic  done
);

  kernel_state_t state;
  hold_cnt_t     hold_cnt;
  logic          desc_accept;

  // Descriptors only land when the unit is at rest
  assign desc_accept = desc_valid && (state == IDLE || state == DONE);

  // ------------------------------
  // Registered reset copy
  // ------------------------------
  always_ff @(posedge ap_clk) begin
    rst_q <= areset_control;
  end

  // ------------------------------
  // State machine
  // ------------------------------
  always_ff @(posedge ap_clk) begin
    if (rst_q) begin
      state        <= IDLE;
      hold_cnt     <= '0;
      setup_start  <= 1'b0;
      bundle_start <= 1'b0;
      setup_flush  <= 1'b0;
      done         <= 1'b0;
    end else begin
      // Single-cycle strobes by default
      setup_start  <= 1'b0;
      bundle_start <= 1'b0;
      setup_flush  <= 1'b0;
      case (state)
        IDLE, DONE: begin
          // New descriptor drops done in the capture cycle
          if (desc_accept) begin
            state       <= SETUP;
            setup_start <= 1'b1;
            done        <= 1'b0;
          end
        end
        SETUP: begin
          if (setup_done) begin
            state        <= BUNDLES;
            bundle_start <= 1'b1;
          end
        end
        BUNDLES: begin
          // Bundles finished, config no longer needed
          if (bundle_done) begin
            state       <= DRAIN;
            setup_flush <= 1'b1;
            hold_cnt    <= '0;
          end
        end
        DRAIN: begin
          // Any activity on the port restarts the quiet window
          if (port_busy) begin
            hold_cnt <= '0;
          end else if (hold_cnt == hold_cnt_t'(DONE_HOLD - 1)) begin
            state <= DONE;
            done  <= 1'b1;
          end else begin
            hold_cnt <= hold_cnt + 1'b1;
          end
        end
        default: begin
          state <= IDLE;
        end
      endcase
    end
  end

  // Descriptor base, fanned out to the setup reader
  always_ff @(posedge ap_clk) begin
    if (desc_accept) begin
      base_q <= desc_base;
    end
  end

  // ------------------------------
  // Checks
  // ------------------------------
  a_state_legal : assert property (@(posedge ap_clk) disable iff (rst_q)
    state inside {IDLE, SETUP, BUNDLES, DRAIN, DONE});

  a_one_start : assert property (@(posedge ap_clk) disable iff (rst_q)
    $onehot0({setup_start, bundle_start}));

endmodule : kernel_control

`default_nettype wire

// File: design/setup_reader.sv
/* Configuration block reader */
`default_nettype none

module setup_reader
  import kernel_cfg_pkg::*;
  import kernel_types_pkg::*;
(
  input  logic      ap_clk,
  input  logic      rst_q,
  input  logic      setup_start,
  input  logic      setup_flush,
  input  addr_t     base_q,
  mem_req_if.requestor link,
  output logic      setup_done,
  output addr_t     data_base,
  output count_t    vertex_count
);

  logic       active;
  logic       req_q;
  // Config words already received, 0 to 2
  logic [1:0] words_done;

  assign link.req  = req_q;
  // First word is the data base, second the count
  assign link.addr = base_q + addr_t'((words_done == 2'd0) ? CFG_DATA_BASE_OFS : CFG_COUNT_OFS);

  // ------------------------------
  // Handshake sequencing
  // ------------------------------
  always_ff @(posedge ap_clk) begin
    if (rst_q || setup_flush) begin
      active     <= 1'b0;
      req_q      <= 1'b0;
      words_done <= 2'd0;
      setup_done <= 1'b0;
    end else begin
      setup_done <= 1'b0;
      if (setup_start) begin
        active     <= 1'b1;
        words_done <= 2'd0;
      end else if (active) begin
        if (req_q) begin
          // Phase 3, drop req once data is in
          if (link.ack) begin
            req_q      <= 1'b0;
            words_done <= words_done + 2'd1;
          end
        end else if (!link.ack) begin
          // Previous ack gone, next read or finish
          if (words_done == 2'd2) begin
            active     <= 1'b0;
            setup_done <= 1'b1;
          end else begin
            req_q <= 1'b1;
          end
        end
      end
    end
  end

  // Latched config, held until the next flush
  always_ff @(posedge ap_clk) begin
    if (setup_flush) begin
      data_base    <= '0;
      vertex_count <= '0;
    end else if (active && req_q && link.ack) begin
      if (words_done == 2'd0) begin
        data_base <= addr_t'(link.rdata);
      end else begin
        vertex_count <= link.rdata[COUNT_W-1:0];
      end
    end
  end

  // req only falls after the arbiter has answered
  a_req_held : assert property (@(posedge ap_clk) disable iff (rst_q)
    link.req && !link.ack |=> link.req);

endmodule : setup_reader

`default_nettype wire

// File: design/bundle_engine.sv
/* Vertex stream accumulator */
`default_nettype none

module bundle_engine
  import kernel_types_pkg::*;
(
  input  logic      ap_clk,
  input  logic      rst_q,
  input  logic      bundle_start,
  input  addr_t     data_base,
  input  count_t    vertex_count,
  mem_req_if.requestor link,
  output logic      bundle_done,
  output word_t     sum
);

  logic   active;
  logic   req_q;
  // Index of the next vertex word
  count_t idx;

  assign link.req  = req_q;
  // Consecutive words from the data base
  assign link.addr = data_base + addr_t'(idx);

  // ------------------------------
  // Read loop
  // ------------------------------
  always_ff @(posedge ap_clk) begin
    if (rst_q) begin
      active      <= 1'b0;
      req_q       <= 1'b0;
      idx         <= '0;
      bundle_done <= 1'b0;
    end else begin
      bundle_done <= 1'b0;
      if (bundle_start) begin
        idx <= '0;
        // Empty run finishes right away
        active      <= (vertex_count != '0);
        bundle_done <= (vertex_count == '0);
      end else if (active) begin
        if (req_q) begin
          if (link.ack) begin
            req_q <= 1'b0;
            idx   <= idx + 1'b1;
          end
        end else if (!link.ack) begin
          // Handshake closed
          if (idx == vertex_count) begin
            active      <= 1'b0;
            bundle_done <= 1'b1;
          end else begin
            req_q <= 1'b1;
          end
        end
      end
    end
  end

  // Running sum, wraps at 2^32
  always_ff @(posedge ap_clk) begin
    if (bundle_start) begin
      sum <= '0;
    end else if (req_q && link.ack) begin
      sum <= sum + link.rdata;
    end
  end

  // Address may not move during a request
  a_addr_stable : assert property (@(posedge ap_clk) disable iff (rst_q)
    link.req |=> !link.req || $stable(link.addr));

endmodule : bundle_engine

`default_nettype wire

// File: design/mem_port_arbiter.sv
/* Shared memory port arbiter */
`default_nettype none

module mem_port_arbiter
  import kernel_cfg_pkg::*;
  import kernel_types_pkg::*;
(
  input  logic    ap_clk,
  input  logic    rst_q,
  mem_req_if.arbiter setup_link,
  mem_req_if.arbiter bundle_link,
  output logic    mem_req,
  output addr_t   mem_addr,
  input  logic    mem_ack,
  input  word_t   mem_rdata,
  output logic    port_busy
);

  req_id_t                   grant;
  req_id_t                   other;
  logic [NUM_REQUESTORS-1:0] pending;
  logic                      port_idle;

  assign pending[REQ_ID_SETUP]  = setup_link.req;
  assign pending[REQ_ID_BUNDLE] = bundle_link.req;

  // ------------------------------
  // Port drive from the owner
  // ------------------------------
  assign mem_req  = pending[grant];
  assign mem_addr = (grant == req_id_t'(REQ_ID_BUNDLE)) ? bundle_link.addr : setup_link.addr;

  // Fully idle means both phases back low
  assign port_idle = !mem_req && !mem_ack;
  assign port_busy = (|pending) || mem_ack;

  // With two requestors round-robin is a swap
  assign other = req_id_t'(~grant);

  // ------------------------------
  // Grant update
  // ------------------------------
  always_ff @(posedge ap_clk) begin
    if (rst_q) begin
      grant <= req_id_t'(REQ_ID_SETUP);
    end else if (port_idle && pending[other]) begin
      // Owner is quiet and the other side waits
      grant <= other;
    end
  end

  // ------------------------------
  // Response routing
  // ------------------------------
  assign setup_link.ack    = mem_ack && (grant == req_id_t'(REQ_ID_SETUP));
  assign setup_link.rdata  = (grant == req_id_t'(REQ_ID_SETUP)) ? mem_rdata : '0;
  assign bundle_link.ack   = mem_ack && (grant == req_id_t'(REQ_ID_BUNDLE));
  assign bundle_link.rdata = (grant == req_id_t'(REQ_ID_BUNDLE)) ? mem_rdata : '0;

  // Checks
  a_one_ack : assert property (@(posedge ap_clk) disable iff (rst_q)
    $onehot0({setup_link.ack, bundle_link.ack}));

endmodule : mem_port_arbiter

`default_nettype wire

// File: design/kernel_cu_top.sv
/* Graph kernel compute unit */
`default_nettype none

module kernel_cu_top
  import kernel_types_pkg::*;
(
  input  logic  ap_clk,
  input  logic  areset_control,
  input  logic  desc_valid,
  input  addr_t desc_base,
  output logic  mem_req,
  output addr_t mem_addr,
  input  logic  mem_ack,
  input  word_t mem_rdata,
  output logic  done,
  output word_t result_sum
);

  logic   rst_q;
  addr_t  base_q;
  logic   setup_start;
  logic   setup_done;
  logic   setup_flush;
  logic   bundle_start;
  logic   bundle_done;
  logic   port_busy;
  // Config handed from setup to bundles
  addr_t  data_base;
  count_t vertex_count;

  // One link per requestor
  mem_req_if setup_link ();
  mem_req_if bundle_link ();

  // ------------------------------
  // Sequencing
  // ------------------------------
  kernel_control u_kernel_control (
    .ap_clk         (ap_clk),
    .areset_control (areset_control),
    .desc_valid     (desc_valid),
    .desc_base      (desc_base),
    .setup_start    (setup_start),
    .setup_done     (setup_done),
    .setup_flush    (setup_flush),
    .bundle_start   (bundle_start),
    .bundle_done    (bundle_done),
    .port_busy      (port_busy),
    .rst_q          (rst_q),
    .base_q         (base_q),
    .done           (done)
  );

  // ------------------------------
  // Requestors
  // ------------------------------
  setup_reader u_setup_reader (
    .ap_clk       (ap_clk),
    .rst_q        (rst_q),
    .setup_start  (setup_start),
    .setup_flush  (setup_flush),
    .base_q       (base_q),
    .link         (setup_link.requestor),
    .setup_done   (setup_done),
    .data_base    (data_base),
    .vertex_count (vertex_count)
  );

  bundle_engine u_bundle_engine (
    .ap_clk       (ap_clk),
    .rst_q        (rst_q),
    .bundle_start (bundle_start),
    .data_base    (data_base),
    .vertex_count (vertex_count),
    .link         (bundle_link.requestor),
    .bundle_done  (bundle_done),
    .sum          (result_sum)
  );

  // Shared port
  mem_port_arbiter u_mem_port_arbiter (
    .ap_clk      (ap_clk),
    .rst_q       (rst_q),
    .setup_link  (setup_link.arbiter),
    .bundle_link (bundle_link.arbiter),
    .mem_req     (mem_req),
    .mem_addr    (mem_addr),
    .mem_ack     (mem_ack),
    .mem_rdata   (mem_rdata),
    .port_busy   (port_busy)
  );

endmodule : kernel_cu_top

`default_nettype wire

// File: tb/tb_kernel_cu.sv
/* Kernel compute unit testbench */
`default_nettype none

module tb_kernel_cu
  import kernel_cfg_pkg::*;
();

  localparam int CLK_PERIOD = 100;
  localparam int NUM_TESTS  = 6;
  // Worst handshake incl. 3-cycle ack delay and grant swap
  localparam int HS_CYCLES  = 10;

  logic        ap_clk;
  logic        areset_control;
  logic        desc_valid;
  logic [31:0] desc_base;
  logic        mem_req;
  logic [31:0] mem_addr;
  logic        mem_ack = 1'b0;
  logic [31:0] mem_rdata = '0;
  logic        done;
  logic [31:0] result_sum;

  // Four words per test
  logic [31:0] patterns [0:4*NUM_TESTS-1];
  logic        patterns_loaded = 1'b0;

  // Memory model state
  logic [31:0] cur_desc;
  logic [31:0] cur_data_base;
  logic [31:0] cur_count;
  logic [31:0] addr_log [$];
  logic [1:0]  ack_delay = 2'd0;
  integer      seed = 32'h1706_fae3;

  int          test_errors = 0;
  int          mon_errors = 0;
  int          failed_tests = 0;
  int          idle_run = 0;
  logic        done_q = 1'b0;

  initial begin
    ap_clk = 1'b0;
    forever #(CLK_PERIOD/2) ap_clk = ~ap_clk;
  end

  kernel_cu_top u_dut (
    .ap_clk         (ap_clk),
    .areset_control (areset_control),
    .desc_valid     (desc_valid),
    .desc_base      (desc_base),
    .mem_req        (mem_req),
    .mem_addr       (mem_addr),
    .mem_ack        (mem_ack),
    .mem_rdata      (mem_rdata),
    .done           (done),
    .result_sum     (result_sum)
  );

  // ------------------------------
  // Memory responder
  // ------------------------------
  // Config block at the descriptor, every other word holds its own address
  function automatic logic [31:0] mem_word(input logic [31:0] addr);
    if (addr == cur_desc) begin
      return cur_data_base;
    end else if (addr == cur_desc + 32'd1) begin
      return cur_count;
    end
    return addr;
  endfunction

  always @(posedge ap_clk) begin
    if (areset_control) begin
      mem_ack   <= 1'b0;
      ack_delay <= 2'd0;
    end else if (!mem_ack && mem_req) begin
      if (ack_delay == 2'd0) begin
        mem_ack   <= 1'b1;
        mem_rdata <= mem_word(mem_addr);
        addr_log.push_back(mem_addr);
      end else begin
        ack_delay <= ack_delay - 2'd1;
      end
    end else if (mem_ack && !mem_req) begin
      // Fresh random delay for the next transfer
      mem_ack   <= 1'b0;
      ack_delay <= 2'($random(seed));
    end
  end

  // Done must never overlap a handshake and needs a quiet window first
  always @(negedge ap_clk) begin
    if (!areset_control) begin
      assert (!(done && (mem_req || mem_ack))) else begin
        $display("MISMATCH at %0t: done high during a handshake", $time);
        mon_errors++;
      end
      if (done && !done_q) begin
        assert (idle_run >= DONE_HOLD) else begin
          $display("MISMATCH at %0t: done after %0d quiet cycles, expected %0d",
                   $time, idle_run, DONE_HOLD);
          mon_errors++;
        end
      end
      idle_run = (mem_req || mem_ack) ? 0 : idle_run + 1;
      done_q   = done;
    end
  end

  task automatic report_mismatch(input string msg);
    $display("MISMATCH at %0t: %s", $time, msg);
    test_errors++;
  endtask

  // ------------------------------
  // One descriptor run
  // ------------------------------
  task automatic run_test(input int t);
    logic [31:0] base;
    logic [31:0] data_base;
    logic [31:0] count;
    logic [31:0] expected;
    logic [31:0] held_sum;
    int          log_start;
    int          errs_before;
    int          i;
    base        = patterns[4*t];
    data_base   = patterns[4*t+1];
    count       = patterns[4*t+2];
    expected    = patterns[4*t+3];
    errs_before = test_errors + mon_errors;
    log_start   = addr_log.size();
    cur_desc      = base;
    cur_data_base = data_base;
    cur_count     = count;
    @(posedge ap_clk);
    desc_valid <= 1'b1;
    desc_base  <= base;
    @(posedge ap_clk);
    desc_valid <= 1'b0;
    @(negedge ap_clk);
    assert (!done) else report_mismatch("done not cleared by new descriptor");
    // Stray descriptor while the config read runs
    while (addr_log.size() < log_start + 1) @(negedge ap_clk);
    @(posedge ap_clk);
    desc_valid <= 1'b1;
    desc_base  <= base ^ 32'h0000_8000;
    @(posedge ap_clk);
    desc_valid <= 1'b0;
    while (!done) @(negedge ap_clk);
    assert (result_sum == expected) else
      report_mismatch($sformatf("sum %h, expected %h", result_sum, expected));
    assert (addr_log.size() - log_start == int'(count) + 2) else
      report_mismatch($sformatf("%0d reads, expected %0d",
                                addr_log.size() - log_start, int'(count) + 2));
    if (addr_log.size() >= log_start + 2) begin
      assert (addr_log[log_start] == base) else
        report_mismatch($sformatf("first read at %h, expected %h", addr_log[log_start], base));
      assert (addr_log[log_start+1] == base + 32'd1) else
        report_mismatch($sformatf("second read at %h", addr_log[log_start+1]));
    end
    for (i = 2; i < addr_log.size() - log_start; i++) begin
      assert (addr_log[log_start+i] == data_base + 32'(i - 2)) else
        report_mismatch($sformatf("vertex read at %h", addr_log[log_start+i]));
    end
    // Done and sum hold while no descriptor comes
    held_sum = result_sum;
    repeat (4) begin
      @(negedge ap_clk);
      assert (done && result_sum == held_sum) else report_mismatch("done or sum not held");
    end
    @(posedge ap_clk);
    if (test_errors + mon_errors == errs_before) begin
      $display("Test %0d passed: count %0d sum %h", t, count, result_sum);
    end else begin
      $display("Test %0d failed: count %0d sum %h", t, count, result_sum);
      failed_tests++;
    end
  endtask

  // ------------------------------
  // Main sequence
  // ------------------------------
  initial begin
    int t;
    areset_control = 1'b1;
    desc_valid     = 1'b0;
    desc_base      = '0;
    cur_desc       = '0;
    cur_data_base  = '0;
    cur_count      = '0;
    $readmemh("tb/kernel_patterns.txt", patterns);
    patterns_loaded = 1'b1;
    repeat (2) @(posedge ap_clk);
    areset_control <= 1'b0;
    repeat (3) @(posedge ap_clk);
    @(negedge ap_clk);
    assert (!done && !mem_req) else report_mismatch("done or mem_req high after reset");
    for (t = 0; t < NUM_TESTS; t++) begin
      run_test(t);
    end
    $display("Summary: %0d tests, %0d failed, %0d errors",
             NUM_TESTS, failed_tests, test_errors + mon_errors);
    if (test_errors + mon_errors == 0) begin
      $display("PASS: all tests");
    end else begin
      $display("FAIL: see errors above");
    end
    $finish;
  end

  // Watchdog sized from the vertex counts in the patterns
  initial begin
    longint limit;
    longint handshakes;
    int     i;
    wait (patterns_loaded);
    handshakes = 0;
    for (i = 0; i < NUM_TESTS; i++) begin
      handshakes += longint'(patterns[4*i+2][15:0]) + 2;
    end
    limit = (handshakes * HS_CYCLES + NUM_TESTS * (DONE_HOLD + 40) + 20) * CLK_PERIOD;
    #(limit);
    $display("Timeout: no result after %0d time units", limit);
    $display("FAIL: see errors above");
    $finish;
  end

endmodule : tb_kernel_cu

`default_nettype wire

// File: tb/kernel_patterns.txt
// desc_base data_base vertex_count expected_sum, hex, one test per line
// zero count follows a non-zero run, count 28 wraps the sum
00000100 00001000 00000004 00004006
00000200 00002000 00000000 00000000
00000300 00003000 00000010 00030078
00000400 f0000000 00000028 8000030c
00000500 00005000 00000001 00005000
00000600 10000000 00000007 70000015

// File: verilog.f
design/kernel_cfg_pkg.sv
design/kernel_types_pkg.sv
design/mem_req_if.sv
design/kernel_control.sv
design/setup_reader.sv
design/bundle_engine.sv
design/mem_port_arbiter.sv
design/kernel_cu_top.sv
tb/tb_kernel_cu.sv

// File: Makefile
# Verilator flow for the kernel compute unit
TOP := tb_kernel_cu

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --assert -f verilog.f --top-module $(TOP)

# Pass only when the log holds the pass line
sim:
	verilator --binary --timing --assert -Wno-fatal -f verilog.f --top-module $(TOP) -o sim_$(TOP)
	./obj_dir/sim_$(TOP) | tee sim.log
	grep -q "PASS: all tests" sim.log

clean:
	rm -rf obj_dir sim.log
